// ==== run_sim.sh ====
#!/bin/sh
# Build and run the toy correlator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module toy_correlator_tb -Mdir obj_dir \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtoy_correlator_tb > sim.log 2>&1 || true
cat sim.log

grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && exit 1 || exit 0

// ==== sim.f ====
source/corr_cfg_pkg.sv
source/vis_word_pkg.sv
source/sig_buffer.sv
source/pair_correlator.sv
source/vis_accumulator.sv
source/vis_streamer.sv
source/toy_correlator.sv
tb/toy_correlator_tb.sv

// ==== source/corr_cfg_pkg.sv ====
`default_nettype none

// Correlator geometry and sample types
package corr_cfg_pkg;

  localparam int NUM_ANT   = 4;
  localparam int NUM_BASE  = 6;  // Cross baselines only
  localparam int BASE_BITS = 3;
  localparam int ANT_BITS  = 2;  // Antenna index width

  // One bit per antenna, set is +1 and clear is -1
  typedef logic [NUM_ANT-1:0] ant_bits_t;

  typedef logic [BASE_BITS-1:0] base_idx_t;

  // Antenna pairs of each baseline
  // (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
  localparam logic [ANT_BITS-1:0] BASE_A [NUM_BASE] = '{
    2'd0,
    2'd0,
    2'd0,
    2'd1,
    2'd1,
    2'd2
  };

  localparam logic [ANT_BITS-1:0] BASE_B [NUM_BASE] = '{
    2'd1,
    2'd2,
    2'd3,
    2'd2,
    2'd3,
    2'd3
  };

endpackage

`default_nettype wire

// ==== source/pair_correlator.sv ====
`default_nettype none

module pair_correlator (
  input  wire                                       vis_clock,
  input  wire                                       vis_reset,
  input  wire                                       rep_valid_i,
  input  wire                                       rep_first_i,
  input  wire                                       rep_last_i,
  input  wire corr_cfg_pkg::base_idx_t              rep_base_i,
  input  wire corr_cfg_pkg::ant_bits_t              rep_idata_i,
  input  wire corr_cfg_pkg::ant_bits_t              rep_qdata_i,
  output logic                                      ps_valid_o,
  output corr_cfg_pkg::base_idx_t                   ps_base_o,
  output logic signed [vis_word_pkg::PSUM_BITS-1:0] ps_re_o,
  output logic signed [vis_word_pkg::PSUM_BITS-1:0] ps_im_o
);

  localparam int PW = vis_word_pkg::PSUM_BITS;

  localparam logic signed [PW-1:0] P_ONE = PW'(1);
  localparam logic signed [PW-1:0] N_ONE = '1;  // -1

  logic [corr_cfg_pkg::ANT_BITS-1:0] ant_a;
  logic [corr_cfg_pkg::ANT_BITS-1:0] ant_b;
  logic                              a_i;
  logic                              a_q;
  logic                              b_i;
  logic                              b_q;
  logic signed [PW-1:0]              term_re;
  logic signed [PW-1:0]              term_im;
  logic signed [PW-1:0]              sum_re;
  logic signed [PW-1:0]              sum_im;
  logic signed [PW-1:0]              next_re;
  logic signed [PW-1:0]              next_im;

  // Product of two 1-bit samples, +1 when the signs agree
  function automatic logic signed [PW-1:0] sign_prod(input logic x, input logic y);
    return (x == y) ? P_ONE : N_ONE;
  endfunction

  always_comb begin
    ant_a = corr_cfg_pkg::BASE_A[rep_base_i];
    ant_b = corr_cfg_pkg::BASE_B[rep_base_i];

    a_i = rep_idata_i[ant_a];
    a_q = rep_qdata_i[ant_a];
    b_i = rep_idata_i[ant_b];
    b_q = rep_qdata_i[ant_b];

    // a times conj(b)
    term_re = sign_prod(a_i, b_i) + sign_prod(a_q, b_q);
    term_im = sign_prod(a_q, b_i) - sign_prod(a_i, b_q);

    // Reload on the first sample of a pass
    next_re = rep_first_i ? term_re : sum_re + term_re;
    next_im = rep_first_i ? term_im : sum_im + term_im;
  end

  always_ff @(posedge vis_clock) begin
    if (rep_valid_i) begin
      sum_re <= next_re;
      sum_im <= next_im;
    end
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      ps_valid_o <= 1'b0;
    end else begin
      ps_valid_o <= rep_valid_i && rep_last_i;
    end
  end

  // Completed pass sum, held while the next pass accumulates
  always_ff @(posedge vis_clock) begin
    if (rep_valid_i && rep_last_i) begin
      ps_base_o <= rep_base_i;
      ps_re_o   <= next_re;
      ps_im_o   <= next_im;
    end
  end

endmodule

`default_nettype wire

// ==== source/sig_buffer.sv ====
`default_nettype none

module sig_buffer #(
  parameter int BLOCK_LEN = 15
) (
  input  wire                          vis_clock,
  input  wire                          vis_reset,
  input  wire                          sig_valid_i,
  input  wire corr_cfg_pkg::ant_bits_t sig_idata_i,
  input  wire corr_cfg_pkg::ant_bits_t sig_qdata_i,
  output logic                         rep_valid_o,
  output logic                         rep_first_o,
  output logic                         rep_last_o,
  output corr_cfg_pkg::base_idx_t      rep_base_o,
  output corr_cfg_pkg::ant_bits_t      rep_idata_o,
  output corr_cfg_pkg::ant_bits_t      rep_qdata_o
);

  localparam int PTR_BITS = (BLOCK_LEN > 1) ? $clog2(BLOCK_LEN) : 1;
  localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(BLOCK_LEN - 1);
  localparam corr_cfg_pkg::base_idx_t LAST_BASE =
      corr_cfg_pkg::base_idx_t'(corr_cfg_pkg::NUM_BASE - 1);

  // Ping-pong banks of I and Q samples
  corr_cfg_pkg::ant_bits_t bank_i [2][BLOCK_LEN];
  corr_cfg_pkg::ant_bits_t bank_q [2][BLOCK_LEN];

  logic                    wr_bank;
  logic [PTR_BITS-1:0]     wr_ptr;
  logic                    bank_done;
  logic                    rd_active;
  logic                    rd_bank;
  logic [PTR_BITS-1:0]     rd_ptr;
  corr_cfg_pkg::base_idx_t rd_base;

  assign bank_done = sig_valid_i && (wr_ptr == LAST_PTR);  // Final sample of a bank

  always_ff @(posedge vis_clock) begin
    if (sig_valid_i) begin
      bank_i[wr_bank][wr_ptr] <= sig_idata_i;
      bank_q[wr_bank][wr_ptr] <= sig_qdata_i;
    end
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      wr_bank <= 1'b0;
      wr_ptr  <= '0;
    end else if (sig_valid_i) begin
      if (wr_ptr == LAST_PTR) begin
        wr_ptr  <= '0;
        wr_bank <= ~wr_bank;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // Replay the full bank once per baseline
  // A replay always finishes before the other bank fills
  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      rd_active <= 1'b0;
      rd_bank   <= 1'b0;
      rd_ptr    <= '0;
      rd_base   <= '0;
    end else if (bank_done) begin
      rd_active <= 1'b1;
      rd_bank   <= wr_bank;  // Bank just filled
      rd_ptr    <= '0;
      rd_base   <= '0;
    end else if (rd_active) begin
      if (rd_ptr == LAST_PTR) begin
        rd_ptr <= '0;
        if (rd_base == LAST_BASE) begin
          rd_active <= 1'b0;
        end else begin
          rd_base <= rd_base + 1'b1;
        end
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assign rep_valid_o = rd_active;
  assign rep_first_o = rd_active && (rd_ptr == '0);
  assign rep_last_o  = rd_active && (rd_ptr == LAST_PTR);
  assign rep_base_o  = rd_base;
  assign rep_idata_o = bank_i[rd_bank][rd_ptr];
  assign rep_qdata_o = bank_q[rd_bank][rd_ptr];

endmodule

`default_nettype wire

// ==== source/toy_correlator.sv ====
`default_nettype none

module toy_correlator #(
  parameter int BLOCK_LEN  = 15,
  parameter int ACC_BLOCKS = 2,
  parameter int OUT_DEPTH  = 8,
  parameter int CREDITS    = 4
) (
  input  wire                          vis_clock,
  input  wire                          vis_reset,
  input  wire                          sig_valid_i,
  input  wire corr_cfg_pkg::ant_bits_t sig_idata_i,
  input  wire corr_cfg_pkg::ant_bits_t sig_qdata_i,
  output logic                         vis_start_o,
  output logic                         vis_frame_o,
  output logic                         out_valid_o,
  output logic [7:0]                   out_data_o,
  output logic                         out_last_o,
  input  wire                          out_credit_i,
  output logic                         overflow_o
);

  logic                                      rep_valid;
  logic                                      rep_first;
  logic                                      rep_last;
  corr_cfg_pkg::base_idx_t                   rep_base;
  corr_cfg_pkg::ant_bits_t                   rep_idata;
  corr_cfg_pkg::ant_bits_t                   rep_qdata;
  logic                                      ps_valid;
  corr_cfg_pkg::base_idx_t                   ps_base;
  logic signed [vis_word_pkg::PSUM_BITS-1:0] ps_re;
  logic signed [vis_word_pkg::PSUM_BITS-1:0] ps_im;
  logic                                      acc_valid;
  logic                                      acc_last;
  vis_word_pkg::vis_word_u                   acc_word;
  logic                                      start_q;
  logic                                      frame_q;

  // Start pulses once on the first replayed block, frame stays up
  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      start_q <= 1'b0;
      frame_q <= 1'b0;
    end else if (!frame_q && rep_valid && rep_first) begin
      start_q <= 1'b1;
      frame_q <= 1'b1;
    end else begin
      start_q <= 1'b0;
    end
  end

  assign vis_start_o = start_q;
  assign vis_frame_o = frame_q;

  sig_buffer #(.BLOCK_LEN(BLOCK_LEN)) u_sig_buffer (
    .vis_clock(vis_clock), .vis_reset(vis_reset), .sig_valid_i(sig_valid_i),
    .sig_idata_i(sig_idata_i), .sig_qdata_i(sig_qdata_i),
    .rep_valid_o(rep_valid), .rep_first_o(rep_first), .rep_last_o(rep_last),
    .rep_base_o(rep_base), .rep_idata_o(rep_idata), .rep_qdata_o(rep_qdata)
  );

  pair_correlator u_pair_correlator (
    .vis_clock(vis_clock), .vis_reset(vis_reset), .rep_valid_i(rep_valid),
    .rep_first_i(rep_first), .rep_last_i(rep_last), .rep_base_i(rep_base),
    .rep_idata_i(rep_idata), .rep_qdata_i(rep_qdata),
    .ps_valid_o(ps_valid), .ps_base_o(ps_base), .ps_re_o(ps_re), .ps_im_o(ps_im)
  );

  vis_accumulator #(.ACC_BLOCKS(ACC_BLOCKS)) u_vis_accumulator (
    .vis_clock(vis_clock), .vis_reset(vis_reset), .ps_valid_i(ps_valid),
    .ps_base_i(ps_base), .ps_re_i(ps_re), .ps_im_i(ps_im),
    .acc_valid_o(acc_valid), .acc_last_o(acc_last), .acc_word_o(acc_word)
  );

  vis_streamer #(.OUT_DEPTH(OUT_DEPTH), .CREDITS(CREDITS)) u_vis_streamer (
    .vis_clock(vis_clock), .vis_reset(vis_reset), .acc_valid_i(acc_valid),
    .acc_last_i(acc_last), .acc_word_i(acc_word), .out_credit_i(out_credit_i),
    .out_valid_o(out_valid_o), .out_data_o(out_data_o), .out_last_o(out_last_o),
    .overflow_o(overflow_o)
  );

endmodule

`default_nettype wire

// ==== source/vis_accumulator.sv ====
`default_nettype none

module vis_accumulator #(
  parameter int ACC_BLOCKS = 2
) (
  input  wire                                      vis_clock,
  input  wire                                      vis_reset,
  input  wire                                      ps_valid_i,
  input  wire corr_cfg_pkg::base_idx_t             ps_base_i,
  input  wire signed [vis_word_pkg::PSUM_BITS-1:0] ps_re_i,
  input  wire signed [vis_word_pkg::PSUM_BITS-1:0] ps_im_i,
  output logic                                     acc_valid_o,
  output logic                                     acc_last_o,
  output vis_word_pkg::vis_word_u                  acc_word_o
);

  localparam int VW = vis_word_pkg::VIS_BITS;
  localparam int CNT_BITS = (ACC_BLOCKS > 1) ? $clog2(ACC_BLOCKS) : 1;
  localparam logic [CNT_BITS-1:0] LAST_BLK = CNT_BITS'(ACC_BLOCKS - 1);
  localparam corr_cfg_pkg::base_idx_t LAST_BASE =
      corr_cfg_pkg::base_idx_t'(corr_cfg_pkg::NUM_BASE - 1);

  // Running totals, one per baseline
  logic signed [VW-1:0] tot_re [corr_cfg_pkg::NUM_BASE];
  logic signed [VW-1:0] tot_im [corr_cfg_pkg::NUM_BASE];

  logic [CNT_BITS-1:0]  blk_cnt;
  logic                 first_blk;
  logic                 final_blk;
  logic                 base_last;
  logic signed [VW-1:0] ext_re;
  logic signed [VW-1:0] ext_im;
  logic signed [VW-1:0] new_re;
  logic signed [VW-1:0] new_im;

  assign first_blk = (blk_cnt == '0);
  assign final_blk = (blk_cnt == LAST_BLK);
  assign base_last = (ps_base_i == LAST_BASE);

  assign ext_re = VW'(ps_re_i);  // Sign extended
  assign ext_im = VW'(ps_im_i);

  // A new period starts from this block's partial sum
  assign new_re = first_blk ? ext_re : tot_re[ps_base_i] + ext_re;
  assign new_im = first_blk ? ext_im : tot_im[ps_base_i] + ext_im;

  always_ff @(posedge vis_clock) begin
    if (ps_valid_i) begin
      tot_re[ps_base_i] <= new_re;
      tot_im[ps_base_i] <= new_im;
    end
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      blk_cnt     <= '0;
      acc_valid_o <= 1'b0;
      acc_last_o  <= 1'b0;
    end else begin
      acc_valid_o <= ps_valid_i && final_blk;
      acc_last_o  <= ps_valid_i && final_blk && base_last;

      // Block ends with baseline 5
      if (ps_valid_i && base_last) begin
        blk_cnt <= final_blk ? '0 : blk_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge vis_clock) begin
    if (ps_valid_i && final_blk) begin
      acc_word_o.cplx.re <= new_re;
      acc_word_o.cplx.im <= new_im;
    end
  end

endmodule

`default_nettype wire

// ==== source/vis_streamer.sv ====
`default_nettype none

module vis_streamer #(
  parameter int OUT_DEPTH = 8,
  parameter int CREDITS   = 4
) (
  input  wire                          vis_clock,
  input  wire                          vis_reset,
  input  wire                          acc_valid_i,
  input  wire                          acc_last_i,
  input  wire vis_word_pkg::vis_word_u acc_word_i,
  input  wire                          out_credit_i,
  output logic                         out_valid_o,
  output logic [7:0]                   out_data_o,
  output logic                         out_last_o,
  output logic                         overflow_o
);

  localparam int PTR_BITS = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(OUT_DEPTH + 1);
  localparam int CR_BITS  = $clog2(CREDITS + 1);
  localparam int IDX_BITS = $clog2(vis_word_pkg::WORD_BYTES);
  localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(OUT_DEPTH - 1);
  localparam logic [IDX_BITS-1:0] LAST_BYTE = IDX_BITS'(vis_word_pkg::WORD_BYTES - 1);

  vis_word_pkg::vis_word_u fifo_word [OUT_DEPTH];
  logic                    fifo_last [OUT_DEPTH];

  logic [PTR_BITS-1:0]     wr_ptr;
  logic [PTR_BITS-1:0]     rd_ptr;
  logic [CNT_BITS-1:0]     fill;
  logic [CR_BITS-1:0]      cr_cnt;
  logic [IDX_BITS-1:0]     byte_idx;
  logic                    full;
  logic                    push;
  logic                    send;
  logic                    pop;
  vis_word_pkg::vis_word_u head;

  assign full = (fill == CNT_BITS'(OUT_DEPTH));
  assign push = acc_valid_i && !full;
  assign send = (fill != '0) && (cr_cnt != '0);  // Needs a word and a credit
  assign pop  = send && (byte_idx == LAST_BYTE);
  assign head = fifo_word[rd_ptr];

  always_ff @(posedge vis_clock) begin
    if (push) begin
      fifo_word[wr_ptr] <= acc_word_i;
      fifo_last[wr_ptr] <= acc_last_i;
    end
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      byte_idx   <= '0;
      cr_cnt     <= CR_BITS'(CREDITS);
      overflow_o <= 1'b0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      if (send) byte_idx <= byte_idx + 1'b1;  // Wraps after byte 7

      fill   <= fill + CNT_BITS'(push) - CNT_BITS'(pop);
      cr_cnt <= cr_cnt - CR_BITS'(send) + CR_BITS'(out_credit_i);

      if (acc_valid_i && full) overflow_o <= 1'b1;  // Word dropped, sticky
    end
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      out_valid_o <= 1'b0;
      out_last_o  <= 1'b0;
    end else begin
      out_valid_o <= send;
      out_last_o  <= pop && fifo_last[rd_ptr];
    end
  end

  always_ff @(posedge vis_clock) begin
    if (send) out_data_o <= head.bytes[LAST_BYTE - byte_idx];  // MSB first
  end

endmodule

`default_nettype wire

// ==== source/vis_word_pkg.sv ====
`default_nettype none

// Visibility word and output stream types
package vis_word_pkg;

  // Per-block partial sum, +-2 per sample over up to 63 samples
  localparam int PSUM_BITS = 8;

  localparam int VIS_BITS = 32;  // Accumulated component width

  localparam int WORD_BYTES = 8;

  // The accumulator writes the complex halves
  // The serializer reads bytes, most significant byte first
  typedef union packed {
    struct packed {
      logic signed [VIS_BITS-1:0] re;  // Upper half
      logic signed [VIS_BITS-1:0] im;
    } cplx;
    logic [WORD_BYTES-1:0][7:0] bytes;
  } vis_word_u;

endpackage

`default_nettype wire

// ==== tb/corr_cases.txt ====
// Lines 0-29: samples, digits = period 1 I, period 1 Q, period 2 I, period 2 Q
// Lines 30-41: expected words {re, im}, baselines 0-5 of period 1 then period 2
f035
3535
a6a6
f035
3535
a6a6
f035
3535
a6a6
f035
3535
a6a6
f035
3535
a6a6
f035
3535
a6a6
f035
3535
a6a6
f035
3535
a6a6
f035
3535
a6a6
f035
3535
a6a6
0000000000000014
0000001400000000
00000000ffffffec
00000000ffffffec
0000001400000028
00000000ffffffec
ffffffec00000028
00000000ffffffec
ffffffd8ffffffec
ffffffd8ffffffec
000000000000003c
ffffffecffffffd8

// ==== tb/toy_correlator_tb.sv ====
`default_nettype none

module toy_correlator_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BLOCK_LEN    = 15;
  localparam int CREDITS      = 4;
  localparam int CASE_LINES   = 30;  // Each line holds a sample of both periods
  localparam int NUM_WORDS    = 12;
  localparam int RAND_SAMPLES = 90;  // Three more periods
  localparam int LIMIT = (2 * CASE_LINES + RAND_SAMPLES) * 8 + 6 * BLOCK_LEN * 4 + 2000;

  logic       vis_clock;
  logic       vis_reset;
  logic       sig_valid_i;
  logic [3:0] sig_idata_i;
  logic [3:0] sig_qdata_i;
  logic       out_credit_i;
  logic       vis_start_o;
  logic       vis_frame_o;
  logic       out_valid_o;
  logic [7:0] out_data_o;
  logic       out_last_o;
  logic       overflow_o;

  logic [63:0] cases [0:CASE_LINES+NUM_WORDS-1];
  logic [63:0] shift_word;
  int          errors;
  int          cycle;
  int          bytes_rx;
  int          words_rx;
  int          credits_back;
  int          start_cnt;
  int          hold_bytes;
  int          seed;
  int          due [$];  // Cycles at which credits go back
  logic        hold;
  logic        perm_hold;
  logic        frame_seen;
  logic        ovf_seen;

  toy_correlator UUT (
    .vis_clock(vis_clock), .vis_reset(vis_reset), .sig_valid_i(sig_valid_i),
    .sig_idata_i(sig_idata_i), .sig_qdata_i(sig_qdata_i),
    .vis_start_o(vis_start_o), .vis_frame_o(vis_frame_o),
    .out_valid_o(out_valid_o), .out_data_o(out_data_o), .out_last_o(out_last_o),
    .out_credit_i(out_credit_i), .overflow_o(overflow_o)
  );

  task automatic expect_equal(input string name, input logic [63:0] exp,
                              input logic [63:0] got);
    assert (exp == got) else begin
      errors++;
      $display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // One strobe, then idle to fill 8 cycles
  task automatic apply_sample(input logic [3:0] i_bits, input logic [3:0] q_bits);
    @(posedge vis_clock);
    #2;
    sig_valid_i = 1'b1;
    sig_idata_i = i_bits;
    sig_qdata_i = q_bits;
    @(posedge vis_clock);
    #2;
    sig_valid_i = 1'b0;
    repeat (6) @(posedge vis_clock);
  endtask

  initial begin
    vis_clock = 1'b0;
    forever #20 vis_clock = ~vis_clock;
  end

  initial begin : watchdog
    forever begin
      @(posedge vis_clock);
      cycle++;
      if (cycle >= LIMIT) begin
        $display("Timeout after %0d cycles, only %0d words received", cycle, words_rx);
        $display("Errors: %0d", errors + 1);
        $display("*** TEST FAILED ***");
        $finish;
      end
    end
  end

  // Return each byte as a credit 3 cycles later unless held back
  initial begin : credit_return
    forever begin
      @(posedge vis_clock);
      #2;
      if (!hold && !perm_hold && due.size() > 0 && due[0] <= cycle) begin
        void'(due.pop_front());
        out_credit_i = 1'b1;
      end else begin
        out_credit_i = 1'b0;
      end
    end
  end

  initial begin : credit_windows
    wait (bytes_rx >= 20);
    hold = 1'b1;
    hold_bytes = 0;
    repeat (50) @(posedge vis_clock);
    assert (hold_bytes <= CREDITS) else begin
      errors++;
      $display("Output kept running with credits withheld (%0d bytes)", hold_bytes);
    end
    hold = 1'b0;
    wait (bytes_rx >= 61);
    hold = 1'b1;
    hold_bytes = 0;
    repeat (40) @(posedge vis_clock);
    assert (hold_bytes <= CREDITS) else begin
      errors++;
      $display("Output kept running in second hold window (%0d bytes)", hold_bytes);
    end
    hold = 1'b0;
  end

  always @(negedge vis_clock) begin
    if (vis_reset) begin
      expect_equal("out_valid_o", 64'd0, 64'(out_valid_o));
      expect_equal("out_last_o", 64'd0, 64'(out_last_o));
      expect_equal("overflow_o", 64'd0, 64'(overflow_o));
      expect_equal("vis_start_o", 64'd0, 64'(vis_start_o));
      expect_equal("vis_frame_o", 64'd0, 64'(vis_frame_o));
    end else begin
      if (vis_start_o) begin
        start_cnt++;
        assert (!frame_seen && vis_frame_o) else begin
          errors++;
          $display("vis_start_o pulsed without vis_frame_o rising with it");
        end
      end
      assert (!frame_seen || vis_frame_o) else begin
        errors++;
        $display("vis_frame_o dropped after it was set");
      end
      assert (frame_seen || !vis_frame_o || vis_start_o) else begin
        errors++;
        $display("vis_frame_o rose without vis_start_o");
      end
      frame_seen = vis_frame_o;
      assert (!ovf_seen || overflow_o) else begin
        errors++;
        $display("overflow_o cleared without a reset");
      end
      ovf_seen = overflow_o;
      if (out_credit_i) credits_back++;
      if (out_valid_o) begin
        bytes_rx++;
        if (hold) hold_bytes++;
        due.push_back(cycle + 3);
        shift_word = {shift_word[55:0], out_data_o};  // Most significant byte first
        if (bytes_rx % 8 == 0) begin
          if (words_rx < NUM_WORDS) begin
            expect_equal("out word", cases[CASE_LINES+words_rx], shift_word);
            expect_equal("out_last_o", 64'(words_rx == 5 || words_rx == 11),
                         64'(out_last_o));
          end
          words_rx++;
        end else if (words_rx < NUM_WORDS) begin
          expect_equal("out_last_o", 64'd0, 64'(out_last_o));
        end
      end
      assert (bytes_rx - credits_back <= CREDITS) else begin
        errors++;
        $display("More bytes outstanding than credits at %0t ns", $time);
      end
    end
  end

  initial begin : main_flow
    logic [7:0] smp;
    int         r;
    vis_reset    = 1'b1;
    sig_valid_i  = 1'b0;
    sig_idata_i  = '0;
    sig_qdata_i  = '0;
    out_credit_i = 1'b0;
    hold         = 1'b0;
    perm_hold    = 1'b0;
    frame_seen   = 1'b0;
    ovf_seen     = 1'b0;
    shift_word   = '0;
    seed         = 32'h2cc287f7;
    $readmemh("tb/corr_cases.txt", cases);
    repeat (8) @(posedge vis_clock);
    #2;
    vis_reset = 1'b0;
    @(negedge vis_clock);
    expect_equal("out_valid_o", 64'd0, 64'(out_valid_o));
    expect_equal("vis_frame_o", 64'd0, 64'(vis_frame_o));

    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < CASE_LINES; k++) begin
        smp = (p == 0) ? cases[k][15:8] : cases[k][7:0];
        apply_sample(smp[7:4], smp[3:0]);
      end
    end
    wait (words_rx >= NUM_WORDS);
    expect_equal("overflow_o", 64'd0, 64'(overflow_o));

    // Starve the output and overrun the word FIFO
    @(posedge vis_clock);
    #2;
    perm_hold = 1'b1;
    repeat (RAND_SAMPLES) begin
      r = $random(seed);
      apply_sample(r[3:0], r[7:4]);
    end
    wait (overflow_o);
    repeat (6 * BLOCK_LEN + 20) @(posedge vis_clock);

    expect_equal("vis_start_o pulses", 64'd1, 64'(start_cnt));
    expect_equal("vis_frame_o", 64'd1, 64'(vis_frame_o));
    $display("Errors: %0d, bytes: %0d, words: %0d", errors, bytes_rx, words_rx);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
